/* Bender.yml */
package:
  name: fme_refine

export_include_dirs:
  - include

sources:
  - design/fme_pkg.sv
  - design/satd_merge.sv
  - design/candidate_compare.sv
  - design/fmv_update.sv
  - design/fme_refine_top.sv
  - target: test
    files:
      - bench/fme_refine_checker.sv
      - bench/fme_refine_tb.sv

/* bench/fme_golden.txt */
// mode(1=8x8) stage(1=quarter) imv0.x imv0.y imv1.x imv1.y, then upper lower per candidate 0..8,
// then cost0 cost1 fmv0.x fmv0.y fmv1.x fmv1.y; negatives as 16-bit two's complement
// 8x8 half, then quarter on top of it
1 0 3 fffe fffb 4 100 120 090 095 080 070 200 010 060 050 070 045 300 300 055 056 090 090 ab ab c fffa ffec 12
1 1 7 7 1 1 040 040 050 050 030 020 060 010 025 030 100 100 020 020 090 010 045 045 40 40 b fffb ffeb 13
// 4x4 half, then quarter
0 0 0 0 a fff6 050 100 040 0f0 060 0e0 070 0d0 080 020 030 0c0 090 0b0 0a0 0a0 0b0 090 30 20 2 0 28 ffd8
0 1 5 5 5 5 200 010 100 020 0ff 030 300 040 0fe 050 400 060 500 070 600 080 700 008 fe 8 2 0 29 ffd9
// ties resolve to the lowest index
1 0 1 1 2 2 080 081 090 090 040 040 070 070 060 030 020 060 0a0 000 050 050 000 080 80 80 6 2 a 6
0 0 ffff ffff 0 3 055 077 055 066 055 066 055 066 055 066 055 066 055 066 055 066 055 066 55 66 fffa fffa 0 a
1 1 0 0 0 0 100 100 0f0 0f0 0e0 0e0 010 0f0 0a0 0a0 090 090 0ff 0ff 080 080 101 000 100 100 fff9 fffa ffff a
// full-range halves and vectors at the edge of the fmv range
1 0 7f ff80 ff80 7f 1fff 1fff 1000 1000 1800 0900 1fff 0001 0fff 0fff 1500 1500 1fff 1ffe 1234 1234 0fff 1000 1ffe 1ffe 1fc fe00 fe00 1fc
0 1 0 0 0 0 300 0ff 200 0fe 250 0fd 100 0fc 180 0fb 190 0fa 1a0 0f9 1b0 0f8 1c0 0f7 100 f7 1fb fe00 fe01 1fd
// mixed signs
1 0 fffd 6 9 ffff 010 020 011 011 030 030 005 020 040 010 008 019 012 012 020 020 022 000 21 21 fff6 18 26 fffc
0 0 2 fffd fffc 1 033 005 022 006 011 007 044 008 055 009 066 00a 077 00b 088 00c 010 00d 10 5 a fff6 ffee 2
1 1 0 0 0 0 100 100 001 002 002 002 010 010 003 001 020 020 030 030 040 040 050 050 3 3 a fff5 ffee 1

/* bench/fme_refine_checker.sv */
`timescale 1ns/1ps
`include "fme_config.svh"

module fme_refine_checker
    import fme_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // expectations latched with the strobe
    input  logic                      start_i,
    input  blk_mode_e                 mode_i,
    input  refine_stage_e             stage_i,
    input  logic [`FME_SATD_BITS-1:0] exp_cost0_i,
    input  logic [`FME_SATD_BITS-1:0] exp_cost1_i,
    input  fmv_t                      exp_fmv0_i,
    input  fmv_t                      exp_fmv1_i,
    // observed DUT outputs
    input  logic                      bcost_valid_i,
    input  logic [`FME_SATD_BITS-1:0] bcost_i,
    input  logic                      best_cand_v_i,
    input  fmv_t                      fmv0_i,
    input  fmv_t                      fmv1_i,
    output int                        test_cnt_o,
    output int                        err_cnt_o
);

    int                        cyc;
    int                        t_start;
    int                        n_cost;
    int                        test_err;
    logic                      busy;
    logic                      reset_seen;
    string                     label;
    blk_mode_e                 mode_q;
    refine_stage_e             stage_q;
    logic [`FME_SATD_BITS-1:0] cost0_q;
    logic [`FME_SATD_BITS-1:0] cost1_q;
    fmv_t                      fmv0_q;
    fmv_t                      fmv1_q;

    task automatic check_value(
        input string             what,
        input logic signed [31:0] got,
        input logic signed [31:0] exp
    );
        if (got !== exp) begin
            $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
            test_err++;
            err_cnt_o++;
        end
    endtask

    task automatic close_test(input string name);
        $display("test %0d %s: %s", test_cnt_o + 1, name, (test_err == 0) ? "ok" : "failed");
        test_cnt_o++;
        test_err = 0;
    endtask

    // ******************************
    // per-edge comparison
    // ******************************

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            cyc        = 0;
            n_cost     = 0;
            test_err   = 0;
            busy       = 1'b0;
            reset_seen = 1'b0;
            test_cnt_o = 0;
            err_cnt_o  = 0;
        end else begin
            // first edge out of reset
            if (!reset_seen) begin
                check_value("bcost_valid_o after reset", bcost_valid_i, 0);
                check_value("best_cand_v_o after reset", best_cand_v_i, 0);
                check_value("fmv0_o after reset", fmv0_i, 0);
                check_value("fmv1_o after reset", fmv1_i, 0);
                close_test("reset");
                reset_seen = 1'b1;
            end
            if (start_i) begin
                busy    = 1'b1;
                t_start = cyc;
                n_cost  = 0;
                mode_q  = mode_i;
                stage_q = stage_i;
                cost0_q = exp_cost0_i;
                cost1_q = exp_cost1_i;
                fmv0_q  = exp_fmv0_i;
                fmv1_q  = exp_fmv1_i;
            end
            if (bcost_valid_i) begin
                if (!busy) begin
                    $display("ERROR @%0t: cost pulse with no search running", $time);
                    err_cnt_o++;
                end else begin
                    check_value("cost pulse delay", cyc - t_start, 2 + n_cost);
                    check_value("bcost_o", bcost_i, (n_cost == 0) ? cost0_q : cost1_q);
                    n_cost++;
                end
            end
            if (best_cand_v_i) begin
                if (!busy) begin
                    $display("ERROR @%0t: best_cand_v_o with no search running", $time);
                    err_cnt_o++;
                end else begin
                    check_value("best_cand_v_o delay", cyc - t_start,
                                (mode_q == MODE_8X8) ? 3 : 4);
                    check_value("cost pulse count", n_cost, (mode_q == MODE_8X8) ? 1 : 2);
                    check_value("fmv0_o.x", fmv0_i.x, fmv0_q.x);
                    check_value("fmv0_o.y", fmv0_i.y, fmv0_q.y);
                    check_value("fmv1_o.x", fmv1_i.x, fmv1_q.x);
                    check_value("fmv1_o.y", fmv1_i.y, fmv1_q.y);
                    if (mode_q == MODE_8X8) begin
                        label = "8x8";
                    end else begin
                        label = "4x4";
                    end
                    if (stage_q == STAGE_HALF) begin
                        label = {label, " half"};
                    end else begin
                        label = {label, " quarter"};
                    end
                    close_test(label);
                    busy = 1'b0;
                end
            end
            cyc++;
        end
    end

endmodule

/* bench/fme_refine_tb.sv */
`timescale 1ns/1ps
`include "fme_config.svh"

module fme_refine_tb
    import fme_pkg::*;
();

    localparam int NUM_REC = 12;
    // mode stage imv0 imv1 18 halves cost0 cost1 fmv0 fmv1
    localparam int REC_LEN = 30;
    localparam int SEED    = 32'h292def7e;

    logic                      clk;
    logic                      rst_n;
    logic                      satd_valid;
    satd_vec_t                 satd;
    blk_mode_e                 blk_mode;
    refine_stage_e             stage;
    imv_t                      imv0;
    imv_t                      imv1;
    logic                      bcost_valid;
    logic [`FME_SATD_BITS-1:0] bcost;
    logic                      best_cand_v;
    fmv_t                      fmv0;
    fmv_t                      fmv1;
    logic [`FME_SATD_BITS-1:0] exp_cost0;
    logic [`FME_SATD_BITS-1:0] exp_cost1;
    fmv_t                      exp_fmv0;
    fmv_t                      exp_fmv1;
    int                        test_cnt;
    int                        err_cnt;
    logic [15:0]               golden [0:NUM_REC*REC_LEN-1];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ******************************
    // DUT and checker
    // ******************************

    fme_refine_top fme_refine_top_i (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .satd_valid_i  (satd_valid),
        .satd_i        (satd),
        .blk_mode_i    (blk_mode),
        .stage_i       (stage),
        .imv0_i        (imv0),
        .imv1_i        (imv1),
        .bcost_valid_o (bcost_valid),
        .bcost_o       (bcost),
        .best_cand_v_o (best_cand_v),
        .fmv0_o        (fmv0),
        .fmv1_o        (fmv1)
    );

    fme_refine_checker u_fme_refine_checker (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .start_i       (satd_valid),
        .mode_i        (blk_mode),
        .stage_i       (stage),
        .exp_cost0_i   (exp_cost0),
        .exp_cost1_i   (exp_cost1),
        .exp_fmv0_i    (exp_fmv0),
        .exp_fmv1_i    (exp_fmv1),
        .bcost_valid_i (bcost_valid),
        .bcost_i       (bcost),
        .best_cand_v_i (best_cand_v),
        .fmv0_i        (fmv0),
        .fmv1_i        (fmv1),
        .test_cnt_o    (test_cnt),
        .err_cnt_o     (err_cnt)
    );

    // one golden record onto the inputs, strobe included
    task automatic apply_record(input int r);
        int base;
        base = r * REC_LEN;
        blk_mode   <= blk_mode_e'(golden[base][0]);
        stage      <= refine_stage_e'(golden[base+1][0]);
        imv0       <= {golden[base+2][`FME_IMV_LEN-1:0], golden[base+3][`FME_IMV_LEN-1:0]};
        imv1       <= {golden[base+4][`FME_IMV_LEN-1:0], golden[base+5][`FME_IMV_LEN-1:0]};
        for (int k = 0; k < `FME_CAND_NUM; k++) begin
            satd[k] <= {golden[base+6+2*k][`FME_SATD_HALF_BITS-1:0],
                        golden[base+7+2*k][`FME_SATD_HALF_BITS-1:0]};
        end
        exp_cost0  <= golden[base+24][`FME_SATD_BITS-1:0];
        exp_cost1  <= golden[base+25][`FME_SATD_BITS-1:0];
        exp_fmv0   <= {golden[base+26][`FME_FMV_LEN-1:0], golden[base+27][`FME_FMV_LEN-1:0]};
        exp_fmv1   <= {golden[base+28][`FME_FMV_LEN-1:0], golden[base+29][`FME_FMV_LEN-1:0]};
        satd_valid <= 1'b1;
    endtask

    // ******************************
    // stimulus
    // ******************************

    initial begin
        int unsigned idle;
        rst_n      = 1'b0;
        satd_valid = 1'b0;
        satd       = '0;
        blk_mode   = MODE_8X8;
        stage      = STAGE_HALF;
        imv0       = '0;
        imv1       = '0;
        exp_cost0  = '0;
        exp_cost1  = '0;
        exp_fmv0   = '0;
        exp_fmv1   = '0;
        void'($urandom(SEED));
        $readmemh("bench/fme_golden.txt", golden);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int r = 0; r < NUM_REC; r++) begin
            idle = $urandom % 4;
            repeat (idle) @(posedge clk);
            apply_record(r);
            @(posedge clk);
            satd_valid <= 1'b0;
            // search done once the vectors land
            do begin
                @(posedge clk);
            end while (best_cand_v !== 1'b1);
        end
        repeat (3) @(posedge clk);
        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0 && test_cnt == NUM_REC + 1) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // generous bound, a search needs under ten cycles
    initial begin
        repeat (NUM_REC * 20) @(posedge clk);
        $display("timeout: searches still running after %0d cycles", NUM_REC * 20);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* design/candidate_compare.sv */
`timescale 1ns/1ps
`include "fme_config.svh"

module candidate_compare
    import fme_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  satd_blk_t  blk_i,
    output best_cand_t best_o
);

    localparam int IDX_W = $clog2(`FME_CAND_NUM);

    // index k sits at column k mod 3, row k div 3 of the grid
    function automatic cand_off_t idx_to_off(input logic [IDX_W-1:0] idx);
        cand_off_t off;
        off.x = 2'(int'(idx) % 3 - 1);
        off.y = 2'(int'(idx) / 3 - 1);
        return off;
    endfunction

    // ******************************
    // minimum search
    // ******************************

    logic [`FME_SATD_BITS-1:0] min_cost;
    logic [IDX_W-1:0]          min_idx;

    // strict compare in the linear scan keeps the lower index on ties
    always_comb begin
        min_cost = blk_i.satd[0];
        min_idx  = '0;
        for (int k = 1; k < `FME_CAND_NUM; k++) begin
            if (blk_i.satd[k] < min_cost) begin
                min_cost = blk_i.satd[k];
                min_idx  = IDX_W'(k);
            end
        end
    end

    // ******************************
    // output register
    // ******************************

    logic                      valid_q;
    part_sel_e                 part_q;
    logic [`FME_SATD_BITS-1:0] cost_q;
    cand_off_t                 off_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            part_q  <= PART0;
        end else begin
            valid_q <= blk_i.valid;
            if (blk_i.valid) begin
                part_q <= blk_i.part;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (blk_i.valid) begin
            cost_q <= min_cost;
            off_q  <= idx_to_off(min_idx);
        end
    end

    assign best_o = '{valid: valid_q, part: part_q, cost: cost_q, off: off_q};

    // ******************************
    // checks
    // ******************************

    // offset of a result stays inside the 3x3 grid
    a_result_in_grid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        best_o.valid |-> (best_o.off.x != -2'sd2 && best_o.off.y != -2'sd2)
    ) else $error("candidate_compare: offset outside grid");

endmodule

/* design/fme_pkg.sv */
`include "fme_config.svh"

package fme_pkg;

    // ******************************
    // modes and stages
    // ******************************

    typedef enum logic {
        MODE_4X4,
        MODE_8X8
    } blk_mode_e;

    typedef enum logic {
        STAGE_HALF,
        STAGE_QUARTER
    } refine_stage_e;

    // which partition vector a result refines
    typedef enum logic [1:0] {
        PART0,
        PART1,
        PART_BOTH
    } part_sel_e;

    // ******************************
    // cost bundles
    // ******************************

    typedef struct packed {
        logic [`FME_SATD_HALF_BITS-1:0] upper;
        logic [`FME_SATD_HALF_BITS-1:0] lower;
    } satd_pair_t;

    typedef satd_pair_t [`FME_CAND_NUM-1:0] satd_vec_t;

    // decode to execute
    typedef struct packed {
        logic                                          valid;
        part_sel_e                                     part;
        logic [`FME_CAND_NUM-1:0][`FME_SATD_BITS-1:0]  satd;
    } satd_blk_t;

    // sub-pel offset, each component in -1..+1
    typedef struct packed {
        logic signed [1:0] x;
        logic signed [1:0] y;
    } cand_off_t;

    // execute to result
    typedef struct packed {
        logic                       valid;
        part_sel_e                  part;
        logic [`FME_SATD_BITS-1:0]  cost;
        cand_off_t                  off;
    } best_cand_t;

    // ******************************
    // motion vectors
    // ******************************

    typedef struct packed {
        logic signed [`FME_IMV_LEN-1:0] x;
        logic signed [`FME_IMV_LEN-1:0] y;
    } imv_t;

    typedef struct packed {
        logic signed [`FME_FMV_LEN-1:0] x;
        logic signed [`FME_FMV_LEN-1:0] y;
    } fmv_t;

endpackage

/* design/fme_refine_top.sv */
`timescale 1ns/1ps
`include "fme_config.svh"

module fme_refine_top
    import fme_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // per-candidate half-block costs
    input  logic                      satd_valid_i,
    input  satd_vec_t                 satd_i,
    // held over a whole search
    input  blk_mode_e                 blk_mode_i,
    input  refine_stage_e             stage_i,
    input  imv_t                      imv0_i,
    input  imv_t                      imv1_i,
    // results
    output logic                      bcost_valid_o,
    output logic [`FME_SATD_BITS-1:0] bcost_o,
    output logic                      best_cand_v_o,
    output fmv_t                      fmv0_o,
    output fmv_t                      fmv1_o
);

    satd_blk_t  blk;
    best_cand_t best;

    // ******************************
    // decode
    // ******************************

    satd_merge u_satd_merge (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .satd_valid_i (satd_valid_i),
        .satd_i       (satd_i),
        .blk_mode_i   (blk_mode_i),
        .blk_o        (blk)
    );

    // ******************************
    // execute
    // ******************************

    candidate_compare u_candidate_compare (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .blk_i   (blk),
        .best_o  (best)
    );

    // cost leaves straight from execute
    assign bcost_valid_o = best.valid;
    assign bcost_o       = best.cost;

    // ******************************
    // result
    // ******************************

    fmv_update u_fmv_update (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .best_i        (best),
        .stage_i       (stage_i),
        .imv0_i        (imv0_i),
        .imv1_i        (imv1_i),
        .fmv0_o        (fmv0_o),
        .fmv1_o        (fmv1_o),
        .best_cand_v_o (best_cand_v_o)
    );

endmodule

/* design/fmv_update.sv */
`timescale 1ns/1ps
`include "fme_config.svh"

module fmv_update
    import fme_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  best_cand_t    best_i,
    input  refine_stage_e stage_i,
    input  imv_t          imv0_i,
    input  imv_t          imv1_i,
    output fmv_t          fmv0_o,
    output fmv_t          fmv1_o,
    output logic          best_cand_v_o
);

    // ******************************
    // refinement rule
    // ******************************

    // half: imv*4 + 2*off, quarter: held + off
    function automatic fmv_t refine(
        input refine_stage_e stage,
        input imv_t          imv,
        input fmv_t          held,
        input cand_off_t     off
    );
        fmv_t res;
        if (stage == STAGE_HALF) begin
            res.x = {imv.x, 2'b00} + {{(`FME_FMV_LEN-3){off.x[1]}}, off.x, 1'b0};
            res.y = {imv.y, 2'b00} + {{(`FME_FMV_LEN-3){off.y[1]}}, off.y, 1'b0};
        end else begin
            res.x = held.x + {{(`FME_FMV_LEN-2){off.x[1]}}, off.x};
            res.y = held.y + {{(`FME_FMV_LEN-2){off.y[1]}}, off.y};
        end
        return res;
    endfunction

    fmv_t fmv0_q;
    fmv_t fmv1_q;
    fmv_t fmv0_next;
    fmv_t fmv1_next;
    logic best_v_q;
    logic last_part;

    assign fmv0_next = refine(stage_i, imv0_i, fmv0_q, best_i.off);
    assign fmv1_next = refine(stage_i, imv1_i, fmv1_q, best_i.off);

    // a search closes on PART1 or PART_BOTH
    assign last_part = (best_i.part == PART1) || (best_i.part == PART_BOTH);

    // ******************************
    // vector registers
    // ******************************

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fmv0_q <= '0;
            fmv1_q <= '0;
        end else if (best_i.valid) begin
            // partition 0 takes PART0 and PART_BOTH
            if (best_i.part != PART1) begin
                fmv0_q <= fmv0_next;
            end
            if (best_i.part != PART0) begin
                fmv1_q <= fmv1_next;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            best_v_q <= 1'b0;
        end else begin
            best_v_q <= best_i.valid && last_part;
        end
    end

    assign fmv0_o        = fmv0_q;
    assign fmv1_o        = fmv1_q;
    assign best_cand_v_o = best_v_q;

    // ******************************
    // checks
    // ******************************

    // after a PART1 result the next valid result must be another partition
    a_no_double_part1: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (best_i.valid && best_i.part == PART1) |=>
            (!(best_i.valid && best_i.part == PART1))
                until (best_i.valid && best_i.part != PART1)
    ) else $error("fmv_update: PART1 result twice in a row");

endmodule

/* design/satd_merge.sv */
`timescale 1ns/1ps
`include "fme_config.svh"

module satd_merge
    import fme_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      satd_valid_i,
    input  satd_vec_t satd_i,
    input  blk_mode_e blk_mode_i,
    output satd_blk_t blk_o
);

    // ******************************
    // state
    // ******************************

    logic                                         valid_q;
    part_sel_e                                    part_q;
    // second 4x4 block still owed to execute
    logic                                         pend_q;
    logic [`FME_CAND_NUM-1:0][`FME_SATD_BITS-1:0] satd_q;
    // lower halves parked for the PART1 cycle
    logic [`FME_CAND_NUM-1:0][`FME_SATD_HALF_BITS-1:0] lower_q;

    // ******************************
    // control
    // ******************************

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            part_q  <= PART0;
            pend_q  <= 1'b0;
        end else begin
            valid_q <= satd_valid_i | pend_q;
            pend_q  <= satd_valid_i && (blk_mode_i == MODE_4X4);
            if (satd_valid_i) begin
                part_q <= (blk_mode_i == MODE_8X8) ? PART_BOTH : PART0;
            end else if (pend_q) begin
                part_q <= PART1;
            end
        end
    end

    // ******************************
    // payload
    // ******************************

    always_ff @(posedge clk_i) begin
        if (satd_valid_i) begin
            for (int k = 0; k < `FME_CAND_NUM; k++) begin
                if (blk_mode_i == MODE_8X8) begin
                    // 8x8 block cost = both halves together
                    satd_q[k] <= {1'b0, satd_i[k].upper} + {1'b0, satd_i[k].lower};
                end else begin
                    satd_q[k] <= {1'b0, satd_i[k].upper};
                end
                lower_q[k] <= satd_i[k].lower;
            end
        end else if (pend_q) begin
            for (int k = 0; k < `FME_CAND_NUM; k++) begin
                satd_q[k] <= {1'b0, lower_q[k]};
            end
        end
    end

    assign blk_o = '{valid: valid_q, part: part_q, satd: satd_q};

    // ******************************
    // checks
    // ******************************

    // the PART1 slot follows a 4x4 strobe, so the next cycle must stay idle
    a_strobe_gap_4x4: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (satd_valid_i && blk_mode_i == MODE_4X4) |=> !satd_valid_i
    ) else $error("satd_merge: 4x4 strobes closer than two cycles");

endmodule

/* flist.f */
+incdir+include
design/fme_pkg.sv
design/satd_merge.sv
design/candidate_compare.sv
design/fmv_update.sv
design/fme_refine_top.sv
bench/fme_refine_checker.sv
bench/fme_refine_tb.sv

/* include/fme_config.svh */
`ifndef FME_CONFIG_SVH
`define FME_CONFIG_SVH

// ******************************
// candidate grid
// ******************************

// 3x3 sub-pel search window
`define FME_CAND_NUM 9

// ******************************
// cost widths
// ******************************

// satd of one half block (upper or lower)
`define FME_SATD_HALF_BITS 13
// merged block satd, one carry bit above a half
`define FME_SATD_BITS (`FME_SATD_HALF_BITS + 1)

// ******************************
// motion vector widths
// ******************************

// signed integer-pel component
`define FME_IMV_LEN 8
// quarter-pel component, two fraction bits below the integer part
`define FME_FMV_LEN (`FME_IMV_LEN + 2)

`endif
